// File: src/fetch_params.svh
// Compile-time constants shared by the fetch front end
// Strand count sets the width of every per-strand mask
// Queue depth must be at least 2 so the almost-full rule can hold back fetches

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Hardware strands served by the barrel
`define FETCH_NUM_STRANDS 4

// Entries in each strand's instruction queue
`define FETCH_QUEUE_DEPTH 4

// Program counter of every strand after reset
`define FETCH_RESET_PC 32'h0000_0000

// Integer multiply opcode, same value in format A and format B
`define FETCH_OP_IMUL 7

`endif

// File: src/fetch_pkg.sv
// Vector types shared by the fetch front end
// Strand index width follows the strand count in the params header
// Instructions are held in big-endian field order after the byte swap

`include "fetch_params.svh"

package fetch_pkg;

	// Byte address of an instruction
	typedef logic [31:0] addr_t;

	// Instruction word, fields in big-endian order
	typedef logic [31:0] instr_t;

	// Index of one strand
	typedef logic [$clog2(`FETCH_NUM_STRANDS)-1:0] strand_t;

	// One bit per strand
	// Used for requests, grants, waits, rollbacks and queue flags
	typedef logic [`FETCH_NUM_STRANDS-1:0] strand_mask_t;

endpackage

// File: src/fetch_request_arbiter.sv
// Picks one strand per cycle for the instruction cache, least recently granted first
// Cache answers one cycle after the grant, so the grant is kept in a register
// A miss without collision parks the strand until its load-complete pulse
// When nothing is granted the address output is a don't care

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_request_arbiter (
	input  logic                    clk,
	input  logic                    reset,
	input  fetch_pkg::strand_mask_t want_i,
	input  fetch_pkg::addr_t        next_pc_i [`FETCH_NUM_STRANDS],
	input  logic                    icache_hit_i,
	input  logic                    icache_collision_i,
	input  fetch_pkg::strand_mask_t icache_load_complete_i,
	output fetch_pkg::strand_mask_t grant_q_o,
	output logic                    icache_request_o,
	output fetch_pkg::addr_t        icache_addr_o,
	output fetch_pkg::strand_t      icache_strand_o
);
	import fetch_pkg::*;

	localparam int NUM = `FETCH_NUM_STRANDS;

	// Recency order, entry 0 is the least recently granted strand
	strand_t      lru_q [NUM];
	strand_t      lru_d [NUM];
	strand_mask_t wait_q;
	strand_mask_t wait_d;
	strand_mask_t eligible;
	strand_mask_t grant;
	strand_t      pick;
	int           pick_pos;
	logic         found;

	// Cache result in this cycle belongs to last cycle's grant
	// Wait set already includes a miss seen now, so that strand is skipped at once
	always_comb
	begin
		wait_d = wait_q & ~icache_load_complete_i;
		if (!icache_hit_i && !icache_collision_i)
			wait_d = wait_d | grant_q_o;
	end

	assign eligible = want_i & ~wait_d;

	// Walk the recency order, first eligible strand wins
	always_comb
	begin
		grant = '0;
		pick = '0;
		pick_pos = 0;
		found = 1'b0;
		for (int i = 0; i < NUM; i++)
		begin
			if (!found && eligible[lru_q[i]])
			begin
				found = 1'b1;
				pick = lru_q[i];
				pick_pos = i;
			end
		end
		if (found)
			grant[pick] = 1'b1;
	end

	// Granted strand moves to the most recent end, the rest shift up
	always_comb
	begin
		lru_d = lru_q;
		if (found)
		begin
			for (int i = 0; i < NUM - 1; i++)
			begin
				if (i >= pick_pos)
					lru_d[i] = lru_q[i + 1];
			end
			lru_d[NUM - 1] = pick;
		end
	end

	assign icache_request_o = found;
	assign icache_addr_o = next_pc_i[pick];
	assign icache_strand_o = pick;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			grant_q_o <= '0;
			wait_q <= '0;
			for (int i = 0; i < NUM; i++)
				lru_q[i] <= strand_t'(i);
		end
		else
		begin
			grant_q_o <= grant;
			wait_q <= wait_d;
			lru_q <= lru_d;
		end
	end

endmodule

// File: src/fetch_predecode.sv
// Predecode of the word returned by the instruction cache
// Memory holds instructions little-endian, so bytes are swapped first
// Static prediction only, backward conditional branches are taken
// Purely combinational, one copy shared by all strands

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_predecode (
	input  fetch_pkg::instr_t icache_data_i,
	output fetch_pkg::instr_t instr_o,
	output logic              branch_predicted_o,
	output fetch_pkg::addr_t  branch_offset_o,
	output logic              long_latency_o
);
	import fetch_pkg::*;

	instr_t     swapped;
	logic       is_branch;
	logic [2:0] branch_type;
	logic       is_conditional;
	logic       is_unconditional;

	assign swapped = {icache_data_i[7:0], icache_data_i[15:8],
		icache_data_i[23:16], icache_data_i[31:24]};
	assign instr_o = swapped;

	// Branch format has the top nibble all ones
	assign is_branch = swapped[31:28] == 4'b1111;
	assign branch_type = swapped[27:25];

	always_comb
	begin
		is_conditional = 1'b0;
		is_unconditional = 1'b0;
		if (is_branch)
		begin
			case (branch_type)
				3'd0, 3'd1, 3'd2, 3'd5: is_conditional = 1'b1;
				// Branch-always and call
				3'd3, 3'd4: is_unconditional = 1'b1;
				default: ;
			endcase
		end
	end

	// Offset field is bits 24 to 5
	assign branch_offset_o = {{12{swapped[24]}}, swapped[24:5]};

	// Negative offset means a backward branch, likely a loop
	assign branch_predicted_o = is_unconditional || (is_conditional && branch_offset_o[31]);

	// Long latency ops go down the longer arithmetic pipeline
	always_comb
	begin
		if (swapped[31:29] == 3'b110)
			// Format A
			long_latency_o = swapped[28] || swapped[28:23] == 6'(`FETCH_OP_IMUL);
		else if (!swapped[31])
			// Format B
			long_latency_o = swapped[30:26] == 5'(`FETCH_OP_IMUL);
		else
			long_latency_o = 1'b0;
	end

endmodule

// File: src/instr_queue.sv
// Small circular FIFO of predecoded instructions for one strand
// Flush empties it in one cycle and wins over an enqueue in the same cycle
// Enqueue while full and dequeue while empty are ignored

`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_queue (
	input  logic              clk,
	input  logic              reset,
	input  logic              flush_i,
	input  logic              enqueue_i,
	input  logic              dequeue_i,
	input  fetch_pkg::addr_t  pc_i,
	input  fetch_pkg::instr_t instr_i,
	input  logic              predicted_i,
	input  logic              long_latency_i,
	output fetch_pkg::addr_t  pc_o,
	output fetch_pkg::instr_t instr_o,
	output logic              predicted_o,
	output logic              long_latency_o,
	output logic              full_o,
	output logic              almost_full_o,
	output logic              empty_o
);
	import fetch_pkg::*;

	localparam int DEPTH = `FETCH_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	addr_t            pc_mem [DEPTH];
	instr_t           instr_mem [DEPTH];
	logic             pred_mem [DEPTH];
	logic             long_mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             do_enq;
	logic             do_deq;

	// Wraps for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full_o = count_q == CNT_W'(DEPTH);
	assign almost_full_o = count_q == CNT_W'(DEPTH - 1);
	assign empty_o = count_q == '0;

	assign do_enq = enqueue_i && !full_o && !flush_i;
	assign do_deq = dequeue_i && !empty_o;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end
		else if (flush_i)
		begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_enq)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (do_deq)
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			// Both at once leaves the count alone
			if (do_enq && !do_deq)
				count_q <= count_q + 1'b1;
			else if (do_deq && !do_enq)
				count_q <= count_q - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_enq)
		begin
			pc_mem[wr_ptr_q] <= pc_i;
			instr_mem[wr_ptr_q] <= instr_i;
			pred_mem[wr_ptr_q] <= predicted_i;
			long_mem[wr_ptr_q] <= long_latency_i;
		end
	end

	// Head of queue, valid only while not empty
	assign pc_o = pc_mem[rd_ptr_q];
	assign instr_o = instr_mem[rd_ptr_q];
	assign predicted_o = pred_mem[rd_ptr_q];
	assign long_latency_o = long_mem[rd_ptr_q];

endmodule

// File: src/strand_fetch_slot.sv
// Fetch state of one strand, program counter plus its instruction queue
// A hit for this strand enqueues the word and moves the pc on the same edge
// A miss leaves the pc where it is so the same address is fetched again
// Rollback flushes the queue and hides the head in the same cycle

`timescale 1ns/1ps
`include "fetch_params.svh"

module strand_fetch_slot (
	input  logic              clk,
	input  logic              reset,
	input  logic              grant_q_i,
	input  logic              icache_hit_i,
	input  fetch_pkg::instr_t instr_i,
	input  logic              branch_predicted_i,
	input  fetch_pkg::addr_t  branch_offset_i,
	input  logic              long_latency_i,
	input  logic              rollback_i,
	input  fetch_pkg::addr_t  rollback_pc_i,
	input  logic              pop_i,
	output logic              want_o,
	output fetch_pkg::addr_t  next_pc_o,
	output logic              head_valid_o,
	output fetch_pkg::addr_t  head_pc_o,
	output fetch_pkg::instr_t head_instr_o,
	output logic              head_predicted_o,
	output logic              head_long_latency_o
);
	import fetch_pkg::*;

	// pc_q is the address of the word in flight while a hit returns
	addr_t pc_q;
	addr_t pc_plus4;
	logic  enqueue;
	logic  full;
	logic  almost_full;
	logic  empty;

	assign enqueue = grant_q_i && icache_hit_i;
	assign pc_plus4 = pc_q + 32'd4;

	// Hold off when a word landing now would leave no room for the next one
	assign want_o = !full && !(almost_full && enqueue);

	// Next address, resolved in the cycle the word comes back
	always_comb
	begin
		if (rollback_i)
			next_pc_o = rollback_pc_i;
		else if (!enqueue)
			next_pc_o = pc_q;
		else if (branch_predicted_i)
			next_pc_o = pc_plus4 + branch_offset_i;
		else
			next_pc_o = pc_plus4;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pc_q <= `FETCH_RESET_PC;
		else
			pc_q <= next_pc_o;
	end

	instr_queue u_queue (
		.clk            (clk),
		.reset          (reset),
		.flush_i        (rollback_i),
		.enqueue_i      (enqueue),
		.dequeue_i      (pop_i),
		.pc_i           (pc_plus4),
		.instr_i        (instr_i),
		.predicted_i    (branch_predicted_i),
		.long_latency_i (long_latency_i),
		.pc_o           (head_pc_o),
		.instr_o        (head_instr_o),
		.predicted_o    (head_predicted_o),
		.long_latency_o (head_long_latency_o),
		.full_o         (full),
		.almost_full_o  (almost_full),
		.empty_o        (empty)
	);

	// Rolled-back strand must not issue its stale head
	assign head_valid_o = !empty && !rollback_i;

endmodule

// File: src/strand_issue_select.sv
// Round-robin drain of the per-strand queues onto the single issue port
// Search starts at the strand after the last one issued
// Nothing is popped while issue_ready_i is low

`timescale 1ns/1ps
`include "fetch_params.svh"

module strand_issue_select (
	input  logic                    clk,
	input  logic                    reset,
	input  fetch_pkg::strand_mask_t head_valid_i,
	input  fetch_pkg::addr_t        head_pc_i [`FETCH_NUM_STRANDS],
	input  fetch_pkg::instr_t       head_instr_i [`FETCH_NUM_STRANDS],
	input  fetch_pkg::strand_mask_t head_predicted_i,
	input  fetch_pkg::strand_mask_t head_long_latency_i,
	input  logic                    issue_ready_i,
	output fetch_pkg::strand_mask_t pop_o,
	output logic                    issue_valid_o,
	output fetch_pkg::strand_t      issue_strand_o,
	output fetch_pkg::addr_t        issue_pc_o,
	output fetch_pkg::instr_t       issue_instr_o,
	output logic                    issue_branch_predicted_o,
	output logic                    issue_long_latency_o
);
	import fetch_pkg::*;

	localparam int NUM = `FETCH_NUM_STRANDS;

	strand_t last_q;
	strand_t pick;
	logic    found;

	// Last candidate checked is last_q itself
	always_comb
	begin
		strand_t idx;
		pick = last_q;
		found = 1'b0;
		for (int i = 1; i <= NUM; i++)
		begin
			idx = strand_t'((int'(last_q) + i) % NUM);
			if (!found && head_valid_i[idx])
			begin
				found = 1'b1;
				pick = idx;
			end
		end
	end

	assign issue_valid_o = issue_ready_i && found;

	always_comb
	begin
		pop_o = '0;
		if (issue_valid_o)
			pop_o[pick] = 1'b1;
	end

	// Head fields of the chosen strand
	assign issue_strand_o = pick;
	assign issue_pc_o = head_pc_i[pick];
	assign issue_instr_o = head_instr_i[pick];
	assign issue_branch_predicted_o = head_predicted_i[pick];
	assign issue_long_latency_o = head_long_latency_i[pick];

	// Start at strand 0 after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_q <= strand_t'(NUM - 1);
		else if (issue_valid_o)
			last_q <= pick;
	end

endmodule

// File: src/fetch_top.sv
// Instruction fetch front end for the four-strand barrel CPU
// External cache answers one cycle after a request, hit or miss
// Issue port is a plain valid level throttled by issue_ready_i
// Rollback of a strand flushes its queue and redirects its pc the same cycle

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top (
	input  logic                    clk,
	input  logic                    reset,
	output logic                    icache_request_o,
	output fetch_pkg::addr_t        icache_addr_o,
	output fetch_pkg::strand_t      icache_strand_o,
	input  logic                    icache_hit_i,
	input  fetch_pkg::instr_t       icache_data_i,
	input  logic                    icache_collision_i,
	input  fetch_pkg::strand_mask_t icache_load_complete_i,
	input  fetch_pkg::strand_mask_t rollback_i,
	input  fetch_pkg::addr_t        rollback_pc_i [`FETCH_NUM_STRANDS],
	input  logic                    issue_ready_i,
	output logic                    issue_valid_o,
	output fetch_pkg::strand_t      issue_strand_o,
	output fetch_pkg::addr_t        issue_pc_o,
	output fetch_pkg::instr_t       issue_instr_o,
	output logic                    issue_branch_predicted_o,
	output logic                    issue_long_latency_o
);
	import fetch_pkg::*;

	localparam int NUM = `FETCH_NUM_STRANDS;

	strand_mask_t want;
	strand_mask_t grant_q;
	addr_t        next_pc [NUM];
	// Predecoded word, broadcast to every slot
	instr_t       pd_instr;
	logic         pd_predicted;
	addr_t        pd_offset;
	logic         pd_long;
	// Queue heads and pops
	strand_mask_t pop;
	strand_mask_t head_valid;
	addr_t        head_pc [NUM];
	instr_t       head_instr [NUM];
	strand_mask_t head_predicted;
	strand_mask_t head_long;

	fetch_request_arbiter u_arbiter (
		.clk                    (clk),
		.reset                  (reset),
		.want_i                 (want),
		.next_pc_i              (next_pc),
		.icache_hit_i           (icache_hit_i),
		.icache_collision_i     (icache_collision_i),
		.icache_load_complete_i (icache_load_complete_i),
		.grant_q_o              (grant_q),
		.icache_request_o       (icache_request_o),
		.icache_addr_o          (icache_addr_o),
		.icache_strand_o        (icache_strand_o)
	);

	fetch_predecode u_predecode (
		.icache_data_i      (icache_data_i),
		.instr_o            (pd_instr),
		.branch_predicted_o (pd_predicted),
		.branch_offset_o    (pd_offset),
		.long_latency_o     (pd_long)
	);

	// Only the slot whose grant bit is set takes the word
	for (genvar s = 0; s < NUM; s++)
	begin : g_slot
		strand_fetch_slot u_slot (
			.clk                 (clk),
			.reset               (reset),
			.grant_q_i           (grant_q[s]),
			.icache_hit_i        (icache_hit_i),
			.instr_i             (pd_instr),
			.branch_predicted_i  (pd_predicted),
			.branch_offset_i     (pd_offset),
			.long_latency_i      (pd_long),
			.rollback_i          (rollback_i[s]),
			.rollback_pc_i       (rollback_pc_i[s]),
			.pop_i               (pop[s]),
			.want_o              (want[s]),
			.next_pc_o           (next_pc[s]),
			.head_valid_o        (head_valid[s]),
			.head_pc_o           (head_pc[s]),
			.head_instr_o        (head_instr[s]),
			.head_predicted_o    (head_predicted[s]),
			.head_long_latency_o (head_long[s])
		);
	end

	strand_issue_select u_issue (
		.clk                      (clk),
		.reset                    (reset),
		.head_valid_i             (head_valid),
		.head_pc_i                (head_pc),
		.head_instr_i             (head_instr),
		.head_predicted_i         (head_predicted),
		.head_long_latency_i      (head_long),
		.issue_ready_i            (issue_ready_i),
		.pop_o                    (pop),
		.issue_valid_o            (issue_valid_o),
		.issue_strand_o           (issue_strand_o),
		.issue_pc_o               (issue_pc_o),
		.issue_instr_o            (issue_instr_o),
		.issue_branch_predicted_o (issue_branch_predicted_o),
		.issue_long_latency_o     (issue_long_latency_o)
	);

endmodule

// File: verif/fetch_sva.sv
// Bound checks on the fetch front end, all at the top level ports
// Sampled on the falling edge, where inputs and outputs have settled
// Keeps its own copy of the miss wait set, built only from port activity
// Failures are counted in fail_count for the testbench to read

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_sva (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    icache_request_i,
	input  fetch_pkg::strand_t      icache_strand_i,
	input  logic                    icache_hit_i,
	input  logic                    icache_collision_i,
	input  fetch_pkg::strand_mask_t icache_load_complete_i,
	input  fetch_pkg::strand_mask_t rollback_i,
	input  fetch_pkg::addr_t        rollback_pc_i [`FETCH_NUM_STRANDS],
	input  logic                    issue_ready_i,
	input  logic                    issue_valid_i,
	input  fetch_pkg::strand_t      issue_strand_i,
	input  fetch_pkg::instr_t       issue_instr_i,
	input  logic                    issue_branch_predicted_i,
	input  logic                    issue_long_latency_i
);
	import fetch_pkg::*;

	localparam int NUM = `FETCH_NUM_STRANDS;

	int           fail_count = 0;
	logic         req_q;
	strand_t      req_strand_q;
	strand_mask_t wait_q;
	strand_mask_t waiting;

	// Miss without collision parks the strand until its load-complete pulse
	always_comb
	begin
		waiting = wait_q & ~icache_load_complete_i;
		if (req_q && !icache_hit_i && !icache_collision_i)
			waiting[req_strand_q] = 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			req_q <= 1'b0;
			req_strand_q <= '0;
			wait_q <= '0;
		end
		else
		begin
			req_q <= icache_request_i;
			req_strand_q <= icache_strand_i;
			wait_q <= waiting;
		end
	end

	// No issue under back-pressure
	a_issue_needs_ready: assert property (@(negedge clk) disable iff (reset)
		issue_valid_i |-> issue_ready_i)
	else
	begin
		fail_count++;
		$error("[ERROR] %0t: issue_valid_o high while issue_ready_i low", $time);
	end

	// Waiting strand stays off the cache port
	a_no_request_while_waiting: assert property (@(negedge clk) disable iff (reset)
		icache_request_i |-> !waiting[icache_strand_i])
	else
	begin
		fail_count++;
		$error("[ERROR] %0t: strand %0d requested while waiting on a miss", $time,
			icache_strand_i);
	end

	// Branch-always and call are always predicted taken
	a_unconditional_predicted: assert property (@(negedge clk) disable iff (reset)
		issue_valid_i && issue_instr_i[31:28] == 4'hF
		&& (issue_instr_i[27:25] == 3'd3 || issue_instr_i[27:25] == 3'd4)
		|-> issue_branch_predicted_i)
	else
	begin
		fail_count++;
		$error("[ERROR] %0t: unconditional branch %h issued not predicted", $time,
			issue_instr_i);
	end

	// Format B long latency only for the multiply opcode
	a_format_b_long_latency: assert property (@(negedge clk) disable iff (reset)
		issue_valid_i && !issue_instr_i[31]
		|-> issue_long_latency_i == (issue_instr_i[30:26] == 5'(`FETCH_OP_IMUL)))
	else
	begin
		fail_count++;
		$error("[ERROR] %0t: format B word %h has wrong long latency flag", $time,
			issue_instr_i);
	end

	for (genvar s = 0; s < NUM; s++)
	begin : g_strand
		// Address zero is never a legal rollback target
		a_rollback_pc_nonzero: assert property (@(negedge clk) disable iff (reset)
			rollback_i[s] |-> rollback_pc_i[s] != '0)
		else
		begin
			fail_count++;
			$error("[ERROR] %0t: rollback of strand %0d to address zero", $time, s);
		end

		// Stale head of a rolled-back strand is hidden
		a_rollback_blocks_issue: assert property (@(negedge clk) disable iff (reset)
			rollback_i[s] |-> !(issue_valid_i && issue_strand_i == strand_t'(s)))
		else
		begin
			fail_count++;
			$error("[ERROR] %0t: strand %0d issued during its rollback", $time, s);
		end
	end

endmodule

bind fetch_top fetch_sva sva0 (
	.clk                      (clk),
	.reset                    (reset),
	.icache_request_i         (icache_request_o),
	.icache_strand_i          (icache_strand_o),
	.icache_hit_i             (icache_hit_i),
	.icache_collision_i       (icache_collision_i),
	.icache_load_complete_i   (icache_load_complete_i),
	.rollback_i               (rollback_i),
	.rollback_pc_i            (rollback_pc_i),
	.issue_ready_i            (issue_ready_i),
	.issue_valid_i            (issue_valid_o),
	.issue_strand_i           (issue_strand_o),
	.issue_instr_i            (issue_instr_o),
	.issue_branch_predicted_i (issue_branch_predicted_o),
	.issue_long_latency_i     (issue_long_latency_o)
);

// File: verif/fetch_tb.sv
// Testbench for the fetch front end
// Cache model answers one cycle after each request with a word fixed by the address
// Reference pcs and per-strand expected queues follow the fetch and rollback rules
// Hits, misses, collisions, rollbacks and ready all come from one seeded stream
// Rollback targets are never zero

`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int NUM = `FETCH_NUM_STRANDS;
	localparam int PERIOD_NS = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_CYCLES = 3000;
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CYCLES + MARGIN_CYCLES) * PERIOD_NS;

	logic         clk;
	logic         reset;
	logic         icache_request_o;
	addr_t        icache_addr_o;
	strand_t      icache_strand_o;
	logic         icache_hit_i;
	instr_t       icache_data_i;
	logic         icache_collision_i;
	strand_mask_t icache_load_complete_i;
	strand_mask_t rollback_i;
	addr_t        rollback_pc_i [NUM];
	logic         issue_ready_i;
	logic         issue_valid_o;
	strand_t      issue_strand_o;
	addr_t        issue_pc_o;
	instr_t       issue_instr_o;
	logic         issue_branch_predicted_o;
	logic         issue_long_latency_o;

	integer       seed;
	int           errors;
	// Reference model per strand
	addr_t        ref_pc [NUM];
	addr_t        exp_pc [NUM][$];
	instr_t       exp_instr [NUM][$];
	int           lc_timer [NUM];
	// Strand of the last issue, round-robin starts after it
	strand_t      last_issued;
	// Request seen last cycle and answered in this one
	logic         req_valid;
	strand_t      req_strand;
	addr_t        req_bus_addr;
	addr_t        req_exp_addr;
	logic         resp_valid;
	logic         resp_hit;
	logic         resp_coll;
	strand_t      resp_strand;
	addr_t        resp_addr;
	strand_mask_t rb_mask;
	addr_t        rb_pc;
	logic         ready_level;
	int           ready_run;

	fetch_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Big-endian instruction word for an address
	// Mixes sequential words, branches, calls and multiplies
	function automatic instr_t make_word(input addr_t addr);
		logic [7:0]  h;
		logic [19:0] off;
		instr_t      w;
		h = addr[9:2] ^ addr[17:10] ^ addr[25:18] ^ {2'b00, addr[31:26]};
		// Word-aligned offset of 4 to 32 bytes
		off = 20'({h[5:3], 2'b00}) + 20'd4;
		case (h[2:0])
			3'd0: w = {4'hF, (h[7] ? 3'd5 : 3'd1), -off, addr[6:2]};
			3'd1: w = {4'hF, (h[7] ? 3'd0 : 3'd2), off, addr[6:2]};
			3'd2: w = {4'hF, 3'd3, (h[6] ? -off : off), addr[6:2]};
			3'd3: w = {4'hF, (h[7] ? 3'd4 : 3'd6), off, addr[6:2]};
			3'd4: w = {3'b110, 6'(`FETCH_OP_IMUL), addr[24:2]};
			3'd5: w = {3'b110, h[7], h[4:0], addr[24:2]};
			3'd6: w = {1'b0, 5'(`FETCH_OP_IMUL), addr[27:2]};
			default: w = {1'b0, h[7:3], addr[27:2]};
		endcase
		return w;
	endfunction

	// Memory order is little-endian
	function automatic instr_t to_little_endian(input instr_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic predicts_taken(input instr_t w);
		logic [2:0] kind;
		kind = w[27:25];
		if (w[31:28] != 4'hF)
			return 1'b0;
		if (kind == 3'd3 || kind == 3'd4)
			return 1'b1;
		// Conditional branch is taken only when backward
		if (kind inside {3'd0, 3'd1, 3'd2, 3'd5})
			return w[24];
		return 1'b0;
	endfunction

	function automatic logic is_long_latency(input instr_t w);
		if (w[31:29] == 3'b110)
			return w[28] || (w[28:23] == 6'(`FETCH_OP_IMUL));
		if (!w[31])
			return w[30:26] == 5'(`FETCH_OP_IMUL);
		return 1'b0;
	endfunction

	function automatic addr_t successor_pc(input addr_t a, input instr_t w);
		addr_t offset;
		offset = {{12{w[24]}}, w[24:5]};
		if (predicts_taken(w))
			return a + 32'd4 + offset;
		return a + 32'd4;
	endfunction

	// Strand the issue port must pick next
	// Returns -1 when no strand has a visible head
	function automatic int round_robin_pick(input strand_t last);
		int pick;
		int idx;
		pick = -1;
		for (int i = NUM; i >= 1; i--)
		begin
			idx = (int'(last) + i) % NUM;
			if (exp_pc[idx].size() > 0 && !rb_mask[idx])
				pick = idx;
		end
		return pick;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// Cache answer and random control inputs on the rising edge
	task automatic drive_cycle();
		strand_mask_t lc;
		strand_t      s;
		int           r;
		lc = '0;
		for (int i = 0; i < NUM; i++)
		begin
			if (lc_timer[i] == 1)
				lc[i] = 1'b1;
			if (lc_timer[i] > 0)
				lc_timer[i]--;
		end
		resp_valid = req_valid;
		resp_strand = req_strand;
		resp_addr = req_exp_addr;
		resp_hit = 1'b0;
		resp_coll = 1'b0;
		if (req_valid)
		begin
			r = {$random(seed)} % 100;
			resp_hit = r < 75;
			resp_coll = r >= 90;
		end
		icache_hit_i <= resp_hit;
		icache_collision_i <= resp_coll;
		icache_data_i <= to_little_endian(make_word(req_bus_addr));
		icache_load_complete_i <= lc;
		rb_mask = '0;
		if ({$random(seed)} % 64 == 0)
		begin
			s = strand_t'({$random(seed)} % NUM);
			rb_mask[s] = 1'b1;
			rb_pc = ({$random(seed)} & 32'h0000_fffc) | 32'h0000_0100;
			rollback_pc_i[s] <= rb_pc;
		end
		rollback_i <= rb_mask;
		// Ready comes in runs so the queues fill up
		if (ready_run == 0)
		begin
			ready_level = ({$random(seed)} % 4) != 0;
			ready_run = 1 + {$random(seed)} % 12;
		end
		ready_run--;
		issue_ready_i <= ready_level;
	endtask

	// Checks on the falling edge where outputs have settled
	task automatic check_cycle();
		strand_t s;
		addr_t   a;
		instr_t  w;
		int      rr_pick;
		// Any visible head must issue while ready is high
		rr_pick = round_robin_pick(last_issued);
		if (issue_ready_i && rr_pick >= 0)
		begin
			assert (issue_valid_o && int'(issue_strand_o) == rr_pick)
			else
				report_mismatch($sformatf("issue valid %b strand %0d, expected strand %0d",
					issue_valid_o, issue_strand_o, rr_pick));
		end
		if (issue_valid_o)
		begin
			s = issue_strand_o;
			last_issued = s;
			assert (exp_pc[s].size() > 0)
			else
				report_mismatch($sformatf("strand %0d issued pc %h, none expected", s,
					issue_pc_o));
			if (exp_pc[s].size() > 0)
			begin
				a = exp_pc[s].pop_front();
				w = exp_instr[s].pop_front();
				assert (issue_pc_o == a)
				else
					report_mismatch($sformatf("strand %0d pc %h, expected %h", s,
						issue_pc_o, a));
				assert (issue_instr_o == w)
				else
					report_mismatch($sformatf("strand %0d instr %h, expected %h", s,
						issue_instr_o, w));
				assert (issue_branch_predicted_o == predicts_taken(w))
				else
					report_mismatch($sformatf("predicted flag wrong for %h", w));
				assert (issue_long_latency_o == is_long_latency(w))
				else
					report_mismatch($sformatf("long latency flag wrong for %h", w));
			end
		end
		// Cache answer for last cycle's request
		if (resp_valid)
		begin
			s = resp_strand;
			if (resp_hit)
			begin
				w = make_word(resp_addr);
				exp_pc[s].push_back(resp_addr + 32'd4);
				exp_instr[s].push_back(w);
				ref_pc[s] = successor_pc(resp_addr, w);
			end
			else if (!resp_coll)
				lc_timer[s] = 2 + {$random(seed)} % 6;
		end
		// Rollback wins over a hit in the same cycle
		for (int i = 0; i < NUM; i++)
		begin
			if (rb_mask[i])
			begin
				exp_pc[i].delete();
				exp_instr[i].delete();
				ref_pc[i] = rb_pc;
			end
		end
		req_valid = icache_request_o;
		req_strand = icache_strand_o;
		req_bus_addr = icache_addr_o;
		if (icache_request_o)
		begin
			req_exp_addr = ref_pc[icache_strand_o];
			assert (icache_addr_o == req_exp_addr)
			else
				report_mismatch($sformatf("strand %0d fetch address %h, expected %h",
					icache_strand_o, icache_addr_o, req_exp_addr));
		end
	endtask

	initial
	begin
		seed = 54713;
		errors = 0;
		reset = 1'b1;
		icache_hit_i = 1'b0;
		icache_data_i = '0;
		icache_collision_i = 1'b0;
		icache_load_complete_i = '0;
		rollback_i = '0;
		issue_ready_i = 1'b1;
		for (int i = 0; i < NUM; i++)
		begin
			rollback_pc_i[i] = 32'h0000_0100;
			ref_pc[i] = `FETCH_RESET_PC;
			lc_timer[i] = 0;
		end
		last_issued = strand_t'(NUM - 1);
		req_valid = 1'b0;
		resp_valid = 1'b0;
		rb_mask = '0;
		rb_pc = '0;
		ready_level = 1'b0;
		ready_run = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// All queues are empty so fetching starts at once
		assert (icache_request_o && !issue_valid_o)
		else
			report_mismatch("request low or issue valid high after reset");
		check_cycle();
		for (int c = 0; c < NUM_CYCLES; c++)
		begin
			@(posedge clk);
			drive_cycle();
			@(negedge clk);
			check_cycle();
		end
		$display("Fetch checks done: %0d scoreboard errors, %0d assertion failures",
			errors, dut0.sva0.fail_count);
		if (errors == 0 && dut0.sva0.fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+src
src/fetch_pkg.sv
src/fetch_request_arbiter.sv
src/fetch_predecode.sv
src/instr_queue.sv
src/strand_fetch_slot.sv
src/strand_issue_select.sv
src/fetch_top.sv
verif/fetch_sva.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= all tests passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
